//--- design/axil_pkg.sv
// AXI4-Lite bus types
// Address, data and response types plus the UART register offsets

package axil_pkg;

    // Byte address within the register window
    typedef logic [3:0] addr_t;

    // Bus word
    typedef logic [31:0] data_t;

    // Response code
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Register offsets
    localparam addr_t REG_TXDATA = 4'h0;
    localparam addr_t REG_RXDATA = 4'h4;
    localparam addr_t REG_STATUS = 4'h8;

endpackage

//--- design/uart_axil_regs.sv
`timescale 1ns/1ps
// UART register block
// AXI4-Lite slave with TXDATA, RXDATA and STATUS registers
// Holds the received byte and the sticky error flags

module uart_axil_regs (
    input  logic             clk,
    input  logic             rst_n,
    uart_core_if.regs        core,
    input  axil_pkg::addr_t  awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  axil_pkg::data_t  wdata,
    input  logic             wvalid,
    output logic             wready,
    output axil_pkg::resp_t  bresp,
    output logic             bvalid,
    input  logic             bready,
    input  axil_pkg::addr_t  araddr,
    input  logic             arvalid,
    output logic             arready,
    output axil_pkg::data_t  rdata,
    output axil_pkg::resp_t  rresp,
    output logic             rvalid,
    input  logic             rready
);

    logic              bus_busy;
    logic              wr_fire;
    logic              rd_fire;
    logic              wr_txdata;
    logic              wr_status;
    logic              wr_ok;
    logic              rd_rxdata;
    logic              rd_ok;
    axil_pkg::data_t   rd_word;
    uart_pkg::data_t   rx_hold;
    logic              rx_valid;
    logic              frame_err;
    logic              overrun;
    uart_pkg::status_t status;

    // One transaction in flight, from ready pulse until response taken
    assign bus_busy = awready | arready | bvalid | rvalid;
    assign wr_fire  = awready && awvalid && wvalid;
    assign rd_fire  = arready && arvalid;

    // Address and data accepted in the same cycle
    assign wready = awready;

    // Write decode
    assign wr_txdata = (awaddr == axil_pkg::REG_TXDATA);
    assign wr_status = (awaddr == axil_pkg::REG_STATUS);
    assign wr_ok     = (wr_txdata && !core.tx_busy) || wr_status;

    // Start only when the transmitter can take the byte
    assign core.tx_start = wr_fire && wr_txdata && !core.tx_busy;
    assign core.tx_data  = wdata[7:0];

    always_comb begin
        status                             = '0;
        status[uart_pkg::STATUS_TX_BUSY]   = core.tx_busy;
        status[uart_pkg::STATUS_RX_VALID]  = rx_valid;
        status[uart_pkg::STATUS_FRAME_ERR] = frame_err;
        status[uart_pkg::STATUS_OVERRUN]   = overrun;
    end

    // Read decode, unknown addresses give zero and SLVERR
    assign rd_rxdata = (araddr == axil_pkg::REG_RXDATA);

    always_comb begin
        rd_word = '0;
        rd_ok   = 1'b0;
        case (araddr)
            axil_pkg::REG_RXDATA: begin
                rd_word = axil_pkg::data_t'(rx_hold);
                rd_ok   = 1'b1;
            end
            axil_pkg::REG_STATUS: begin
                rd_word = axil_pkg::data_t'(status);
                rd_ok   = 1'b1;
            end
            default: begin
                rd_word = '0;
                rd_ok   = 1'b0;
            end
        endcase
    end

    // Handshakes, write wins if both arrive together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= !bus_busy && awvalid && wvalid;
            arready <= !bus_busy && !(awvalid && wvalid) && arvalid;

            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payload, only meaningful with its valid
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
    end

    // Sticky status, a new event wins over a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            if (rd_fire && rd_rxdata) begin
                rx_valid <= 1'b0;
            end
            // Write-one-to-clear on the error bits
            if (wr_fire && wr_status) begin
                if (wdata[uart_pkg::STATUS_FRAME_ERR]) begin
                    frame_err <= 1'b0;
                end
                if (wdata[uart_pkg::STATUS_OVERRUN]) begin
                    overrun <= 1'b0;
                end
            end
            if (core.rx_strobe) begin
                if (core.rx_frame_err) begin
                    frame_err <= 1'b1;
                end else begin
                    rx_valid <= 1'b1;
                    // Unread byte is about to be replaced
                    if (rx_valid && !(rd_fire && rd_rxdata)) begin
                        overrun <= 1'b1;
                    end
                end
            end
        end
    end

    // Good frames only, overwrites an unread byte
    always_ff @(posedge clk) begin
        if (core.rx_strobe && !core.rx_frame_err) begin
            rx_hold <= core.rx_data;
        end
    end

endmodule

//--- design/uart_core_if.sv
`timescale 1ns/1ps
// UART core link
// Joins the register block to the transmitter and the receiver

interface uart_core_if;

    // Transmit side
    uart_pkg::data_t tx_data;
    logic            tx_start;
    logic            tx_busy;

    // Receive side, strobe and error share one cycle
    uart_pkg::data_t rx_data;
    logic            rx_strobe;
    logic            rx_frame_err;

    modport regs (
        output tx_data,
        output tx_start,
        input  tx_busy,
        input  rx_data,
        input  rx_strobe,
        input  rx_frame_err
    );

    modport tx (
        input  tx_data,
        input  tx_start,
        output tx_busy
    );

    modport rx (
        output rx_data,
        output rx_strobe,
        output rx_frame_err
    );

endinterface

//--- design/uart_pkg.sv
// UART frame types
// Character and status vector shared by the serial engines and the register block

package uart_pkg;

    // One character on the serial line
    typedef logic [7:0] data_t;

    // Status register contents
    typedef logic [3:0] status_t;

    // Bit positions inside status_t
    localparam int STATUS_TX_BUSY   = 0;
    localparam int STATUS_RX_VALID  = 1;
    localparam int STATUS_FRAME_ERR = 2;
    localparam int STATUS_OVERRUN   = 3;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/1ps
// UART receiver
// Synchronizes the line, samples each bit mid-period and judges the stop bit

module uart_rx #(
    parameter int CLK_FREQ_HZ = 25_000_000,
    parameter int BAUD_RATE   = 1_000_000
) (
    input  logic    clk,
    input  logic    rst_n,
    uart_core_if.rx core,
    input  logic    rx
);

    localparam int DIVIDER = CLK_FREQ_HZ / BAUD_RATE;
    localparam int DIV_W   = $clog2(DIVIDER);

    typedef logic [DIV_W:0] baud_cnt_t;

    // Full bit period between samples
    localparam baud_cnt_t BIT_LOAD  = baud_cnt_t'(DIVIDER - 2);
    // First sample lands near the middle of the start bit
    localparam baud_cnt_t HALF_LOAD = baud_cnt_t'(DIVIDER / 2 - 2);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

    rx_state_t       state;
    logic            rx_meta;
    logic            rx_sync;
    baud_cnt_t       baud_cnt;
    logic            baud_tick;
    logic [2:0]      bit_idx;
    uart_pkg::data_t shift;
    logic            strobe;
    logic            frame_err;

    assign baud_tick         = baud_cnt[DIV_W];
    // Shift register holds the byte until the next frame's data bits
    assign core.rx_data      = shift;
    assign core.rx_strobe    = strobe;
    assign core.rx_frame_err = frame_err;

    // Two-flop synchronizer, idles high like the line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            baud_cnt  <= HALF_LOAD;
            bit_idx   <= '0;
            strobe    <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            strobe <= 1'b0;

            // Held at half period while idle so a falling edge starts mid-bit timing
            if (state == IDLE) begin
                baud_cnt <= HALF_LOAD;
            end else if (baud_tick) begin
                baud_cnt <= BIT_LOAD;
            end else begin
                baud_cnt <= baud_cnt - baud_cnt_t'(1);
            end

            case (state)
                IDLE: begin
                    if (!rx_sync) begin
                        state <= START;
                    end
                end
                START: begin
                    // Line back high at mid start bit means a glitch
                    if (baud_tick) begin
                        if (rx_sync) begin
                            state <= IDLE;
                        end else begin
                            state   <= DATA;
                            bit_idx <= '0;
                        end
                    end
                end
                DATA: begin
                    if (baud_tick) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    // Low stop bit is a framing error
                    if (baud_tick) begin
                        strobe    <= 1'b1;
                        frame_err <= !rx_sync;
                        state     <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == DATA && baud_tick) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

endmodule

//--- design/uart_top.sv
`timescale 1ns/1ps
// UART peripheral top level
// AXI4-Lite register port and 8N1 serial pins, baud rate fixed by parameters

module uart_top #(
    parameter int CLK_FREQ_HZ = 25_000_000,
    parameter int BAUD_RATE   = 1_000_000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  axil_pkg::addr_t  awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  axil_pkg::data_t  wdata,
    input  logic             wvalid,
    output logic             wready,
    output axil_pkg::resp_t  bresp,
    output logic             bvalid,
    input  logic             bready,
    input  axil_pkg::addr_t  araddr,
    input  logic             arvalid,
    output logic             arready,
    output axil_pkg::data_t  rdata,
    output axil_pkg::resp_t  rresp,
    output logic             rvalid,
    input  logic             rready,
    output logic             tx,
    input  logic             rx
);

    // Link between register block and serial engines
    uart_core_if core_if ();

    uart_axil_regs uart_axil_regs_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .core    (core_if.regs),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    uart_tx #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD_RATE   (BAUD_RATE)
    ) uart_tx_i (
        .clk   (clk),
        .rst_n (rst_n),
        .core  (core_if.tx),
        .tx    (tx)
    );

    uart_rx #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD_RATE   (BAUD_RATE)
    ) uart_rx_i (
        .clk   (clk),
        .rst_n (rst_n),
        .core  (core_if.rx),
        .rx    (rx)
    );

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps
// UART transmitter
// Sends one 8N1 frame per start pulse, paced by its own baud counter

module uart_tx #(
    parameter int CLK_FREQ_HZ = 25_000_000,
    parameter int BAUD_RATE   = 1_000_000
) (
    input  logic    clk,
    input  logic    rst_n,
    uart_core_if.tx core,
    output logic    tx
);

    // Clocks per bit and counter width
    localparam int DIVIDER = CLK_FREQ_HZ / BAUD_RATE;
    localparam int DIV_W   = $clog2(DIVIDER);

    // One extra bit so the sign marks the end of a bit period
    typedef logic [DIV_W:0] baud_cnt_t;

    // Reload of DIVIDER-2 makes the sign fire DIVIDER clocks apart
    localparam baud_cnt_t BIT_LOAD = baud_cnt_t'(DIVIDER - 2);

    baud_cnt_t  baud_cnt;
    logic       baud_tick;
    logic [9:0] frame;
    logic [3:0] bits_left;

    assign baud_tick    = baud_cnt[DIV_W];
    assign core.tx_busy = |bits_left;

    // Line idles high since shifted-in bits are ones
    assign tx = frame[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt  <= BIT_LOAD;
            frame     <= '1;
            bits_left <= '0;
        end else if (core.tx_start && !core.tx_busy) begin
            // Stop bit, data LSB first, start bit
            frame     <= {1'b1, core.tx_data, 1'b0};
            bits_left <= 4'd10;
            baud_cnt  <= BIT_LOAD;
        end else if (core.tx_busy) begin
            if (baud_tick) begin
                // Next bit onto the line
                frame     <= {1'b1, frame[9:1]};
                bits_left <= bits_left - 4'd1;
                baud_cnt  <= BIT_LOAD;
            end else begin
                baud_cnt <= baud_cnt - baud_cnt_t'(1);
            end
        end
    end

endmodule

//--- list.f
design/uart_pkg.sv
design/axil_pkg.sv
design/uart_core_if.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_axil_regs.sv
design/uart_top.sv
verif/uart_properties.sv
verif/uart_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module uart_tb -o uart_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/uart_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "PASS: all tests" sim.log; then
    exit 0
fi
exit 1

//--- verif/uart_properties.sv
`timescale 1ns/1ps
// UART interface properties
// Serial idle level and AXI4-Lite handshake rules checked inside the top level

module uart_properties (
    input logic clk,
    input logic rst_n,
    input logic tx,
    input logic tx_busy,
    input logic awvalid,
    input logic wvalid,
    input logic awready,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready
);

    // Line rests high whenever nothing is being sent
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
        else $error("tx low while transmitter idle");

    // Write response stays up until the master takes it
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // Same for read data
    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // Both channels accepted in one cycle and only while both valids are up
    aw_w_ready_pair: assert property (@(posedge clk) disable iff (!rst_n)
        (awready || wready) |-> (awready && wready && awvalid && wvalid))
        else $error("awready and wready not raised together on a full write request");

endmodule

bind uart_top uart_properties uart_properties_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx      (tx),
    .tx_busy (core_if.tx_busy),
    .awvalid (awvalid),
    .wvalid  (wvalid),
    .awready (awready),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready)
);

//--- verif/uart_tb.sv
`timescale 1ns/1ps
// UART peripheral testbench
// Directed tests over the AXI4-Lite port and the serial pins

module uart_tb;

    localparam int CLK_FREQ_HZ = 25_000_000;
    localparam int BAUD_RATE   = 1_000_000;
    localparam int BIT_CYCLES  = CLK_FREQ_HZ / BAUD_RATE;
    // 40 frames of 250 cycles plus margin
    localparam int TIMEOUT_CYCLES = 40 * 250 + 2000;
    localparam int POLL_LIMIT     = 100;
    localparam logic [31:0] LFSR_SEED = 32'h22ae_6c66;

    // Expected STATUS values with bit 0 tx_busy, 1 rx_valid, 2 frame_err and 3 overrun
    localparam uart_pkg::status_t ST_CLEAR     = 4'b0000;
    localparam uart_pkg::status_t ST_FRAME_ERR = 4'b0100;
    localparam uart_pkg::status_t ST_OVERRUN   = 4'b1000;
    localparam uart_pkg::status_t ST_OVR_VALID = 4'b1010;

    logic            clk;
    logic            rst_n;
    axil_pkg::addr_t awaddr;
    logic            awvalid;
    logic            awready;
    axil_pkg::data_t wdata;
    logic            wvalid;
    logic            wready;
    axil_pkg::resp_t bresp;
    logic            bvalid;
    logic            bready;
    axil_pkg::addr_t araddr;
    logic            arvalid;
    logic            arready;
    axil_pkg::data_t rdata;
    axil_pkg::resp_t rresp;
    logic            rvalid;
    logic            rready;
    logic            tx;
    logic            rx;

    logic [31:0] lfsr;
    int          error_count;
    int          check_count;
    int          cycle_count = 0;

    uart_top #(
        .CLK_FREQ_HZ (CLK_FREQ_HZ),
        .BAUD_RATE   (BAUD_RATE)
    ) uart_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .tx      (tx),
        .rx      (rx)
    );

    // 40 ns clock
    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Hard stop if a test never finishes
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic report_failure(input string what);
        error_count++;
        $display("ERROR: %s", what);
    endtask

    task automatic check_data(input string name, input uart_pkg::data_t got,
                              input uart_pkg::data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input uart_pkg::status_t got,
                                input uart_pkg::status_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s: got 0x%01h expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axil_pkg::resp_t got,
                              input axil_pkg::resp_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s: got 0x%01h expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input axil_pkg::data_t got,
                              input axil_pkg::data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // Galois LFSR shifting right with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic random_byte(output uart_pkg::data_t value);
        for (int i = 0; i < 8; i++) begin
            lfsr     = lfsr_step(lfsr);
            value[i] = lfsr[0];
        end
    endtask

    // Starts and returns on a falling edge
    task automatic axil_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                              output axil_pkg::resp_t resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        if (wready !== 1'b1) begin
            report_failure("wready not raised together with awready");
        end
        // Handshake completes on the rising edge in between
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input axil_pkg::addr_t addr, output axil_pkg::data_t data,
                             output axil_pkg::resp_t resp);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // Poll STATUS until one bit reaches the wanted level
    task automatic wait_status_bit(input int bit_pos, input logic level,
                                   output uart_pkg::status_t status);
        axil_pkg::data_t word;
        axil_pkg::resp_t resp;
        int              polls;
        polls = 0;
        axil_read(axil_pkg::REG_STATUS, word, resp);
        while (word[bit_pos] != level && polls < POLL_LIMIT) begin
            axil_read(axil_pkg::REG_STATUS, word, resp);
            polls++;
        end
        check_resp("rresp STATUS", resp, axil_pkg::RESP_OKAY);
        if (word[bit_pos] != level) begin
            report_failure($sformatf("STATUS bit %0d never reached %0b", bit_pos, level));
        end
        status = word[3:0];
    endtask

    // 8N1 frame onto rx where a bad stop bit stays low past its mid-bit sample
    task automatic serial_send(input uart_pkg::data_t value, input logic bad_stop);
        rx = 1'b0;
        repeat (BIT_CYCLES) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            rx = value[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        if (bad_stop) begin
            rx = 1'b0;
            repeat (BIT_CYCLES - 8) @(negedge clk);
            rx = 1'b1;
            repeat (BIT_CYCLES + 8) @(negedge clk);
        end else begin
            rx = 1'b1;
            repeat (BIT_CYCLES) @(negedge clk);
        end
        // Idle gap before the next frame
        repeat (BIT_CYCLES) @(negedge clk);
    endtask

    // Finds the start edge on tx, then samples every bit at mid-period
    task automatic serial_capture(output uart_pkg::data_t value);
        @(negedge clk);
        while (tx) @(negedge clk);
        repeat (BIT_CYCLES / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            report_failure("tx start bit not low at mid-bit");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            value[i] = tx;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        if (tx !== 1'b1) begin
            report_failure("tx stop bit not high at mid-bit");
        end
    endtask

    task automatic test_reset_state;
        uart_pkg::status_t status;
        wait_status_bit(uart_pkg::STATUS_TX_BUSY, 1'b0, status);
        check_status("status after reset", status, ST_CLEAR);
        if (tx !== 1'b1) begin
            report_failure("tx pin not high after reset");
        end
    endtask

    task automatic test_transmit;
        uart_pkg::data_t   sent;
        uart_pkg::data_t   got;
        axil_pkg::resp_t   resp;
        uart_pkg::status_t status;
        for (int n = 0; n < 4; n++) begin
            random_byte(sent);
            fork
                axil_write(axil_pkg::REG_TXDATA, axil_pkg::data_t'(sent), resp);
                serial_capture(got);
            join
            check_resp("bresp TXDATA", resp, axil_pkg::RESP_OKAY);
            check_data("tx byte", got, sent);
            wait_status_bit(uart_pkg::STATUS_TX_BUSY, 1'b0, status);
            check_status("status after tx", status, ST_CLEAR);
        end
    endtask

    task automatic test_receive;
        uart_pkg::data_t   sent;
        axil_pkg::data_t   word;
        axil_pkg::resp_t   resp;
        uart_pkg::status_t status;
        random_byte(sent);
        serial_send(sent, 1'b0);
        wait_status_bit(uart_pkg::STATUS_RX_VALID, 1'b1, status);
        axil_read(axil_pkg::REG_RXDATA, word, resp);
        check_resp("rresp RXDATA", resp, axil_pkg::RESP_OKAY);
        check_word("rdata RXDATA", word, axil_pkg::data_t'(sent));
        // Reading RXDATA empties the holding register
        wait_status_bit(uart_pkg::STATUS_RX_VALID, 1'b0, status);
        check_status("status after rx read", status, ST_CLEAR);
    endtask

    task automatic test_frame_error;
        uart_pkg::data_t   sent;
        axil_pkg::resp_t   resp;
        uart_pkg::status_t status;
        random_byte(sent);
        serial_send(sent, 1'b1);
        wait_status_bit(uart_pkg::STATUS_FRAME_ERR, 1'b1, status);
        check_status("status after bad stop", status, ST_FRAME_ERR);
        axil_write(axil_pkg::REG_STATUS, 32'h4, resp);
        check_resp("bresp STATUS", resp, axil_pkg::RESP_OKAY);
        wait_status_bit(uart_pkg::STATUS_FRAME_ERR, 1'b0, status);
        check_status("status after frame_err clear", status, ST_CLEAR);
    endtask

    task automatic test_overrun;
        uart_pkg::data_t   first;
        uart_pkg::data_t   second;
        axil_pkg::data_t   word;
        axil_pkg::resp_t   resp;
        uart_pkg::status_t status;
        random_byte(first);
        random_byte(second);
        serial_send(first, 1'b0);
        serial_send(second, 1'b0);
        wait_status_bit(uart_pkg::STATUS_OVERRUN, 1'b1, status);
        check_status("status after overrun", status, ST_OVR_VALID);
        // Second byte replaced the unread first one
        axil_read(axil_pkg::REG_RXDATA, word, resp);
        check_resp("rresp RXDATA", resp, axil_pkg::RESP_OKAY);
        check_data("rx byte after overrun", word[7:0], second);
        wait_status_bit(uart_pkg::STATUS_RX_VALID, 1'b0, status);
        check_status("status after overrun read", status, ST_OVERRUN);
        axil_write(axil_pkg::REG_STATUS, 32'h8, resp);
        check_resp("bresp STATUS", resp, axil_pkg::RESP_OKAY);
        wait_status_bit(uart_pkg::STATUS_OVERRUN, 1'b0, status);
        check_status("status after overrun clear", status, ST_CLEAR);
    endtask

    task automatic test_bus_errors;
        uart_pkg::data_t   first;
        uart_pkg::data_t   second;
        uart_pkg::data_t   got;
        axil_pkg::data_t   word;
        axil_pkg::resp_t   resp_first;
        axil_pkg::resp_t   resp_second;
        axil_pkg::resp_t   resp;
        uart_pkg::status_t status;
        random_byte(first);
        random_byte(second);
        // Second write lands while the first frame is on the line
        fork
            begin
                axil_write(axil_pkg::REG_TXDATA, axil_pkg::data_t'(first), resp_first);
                axil_write(axil_pkg::REG_TXDATA, axil_pkg::data_t'(second), resp_second);
            end
            serial_capture(got);
        join
        check_resp("bresp first TXDATA", resp_first, axil_pkg::RESP_OKAY);
        check_resp("bresp busy TXDATA", resp_second, axil_pkg::RESP_SLVERR);
        check_data("tx byte under busy write", got, first);
        wait_status_bit(uart_pkg::STATUS_TX_BUSY, 1'b0, status);
        check_status("status after busy write", status, ST_CLEAR);
        axil_read(4'hC, word, resp);
        check_resp("rresp 0xC", resp, axil_pkg::RESP_SLVERR);
        check_word("rdata 0xC", word, '0);
        axil_write(axil_pkg::REG_RXDATA, 32'h5A, resp);
        check_resp("bresp RXDATA", resp, axil_pkg::RESP_SLVERR);
    endtask

    initial begin
        rst_n       = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        rx          = 1'b1;
        lfsr        = LFSR_SEED;
        error_count = 0;
        check_count = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_reset_state();
        test_transmit();
        test_receive();
        test_frame_error();
        test_overrun();
        test_bus_errors();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
